// ==== sources.f ====
+incdir+tests
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/cpu_top.sv
tests/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/fetch_stage.sv
      - rtl/reg_file.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/memory_stage.sv
      - rtl/hazard_unit.sv
      - rtl/cpu_top.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/cpu_tb.sv

// ==== tests/cpu_tb_model.svh ====
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic word_t rand_bits(int n);
    word_t v;
    logic  fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        v    = {v[30:0], fb};
    end
    return v;
endfunction

// R-format word, kind sits in op bits 29:28
function automatic word_t enc_r(logic [1:0] kind, alu_op_e alu, reg_addr_t rs, reg_addr_t rt,
                                reg_addr_t rd);
    return {2'b00, kind, 2'b00, rs, rt, rd, 5'b0, alu, 3'b0};
endfunction

// Load immediate into r0, op bit 2 set so it writes back
function automatic word_t enc_li(word_t imm);
    return {2'b01, 4'b0100, imm[IMM_W-1:0]};
endfunction

// Word index into the data memory, upper address bits alias
function automatic logic [DMEM_AW-1:0] mem_index(word_t addr);
    return addr[2 +: DMEM_AW];
endfunction

function automatic word_t fill_word(int idx);
    return word_t'(idx) * 32'h9e37_79b9 ^ 32'h5a5a_0f0f;   // Every index bit matters
endfunction

function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
    case (op)
        ALU_ADD:    return a + b;
        ALU_SUB:    return a - b;
        ALU_AND:    return a & b;
        ALU_OR:     return a | b;
        ALU_XOR:    return a ^ b;
        ALU_NOR:    return ~(a | b);
        ALU_PASS_A: return a;
        default:    return b;
    endcase
endfunction

// In-order ISA model, no pipeline; fills the expected store list and memory image
function automatic void run_model(int len);
    word_t     regs [NUM_REGS];     // Unloaded registers stay X
    word_t     w;
    word_t     a;
    word_t     b;
    word_t     r;
    reg_addr_t rd;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < DMEM_DEPTH; i++) begin
        exp_mem[i] = fill_word(i);
    end
    for (int pc = 0; pc < len; pc++) begin
        w  = prog[pc];
        a  = regs[w[RS_LSB +: REG_ADDR_W]];
        b  = regs[w[RT_LSB +: REG_ADDR_W]];
        rd = w[RD_LSB +: REG_ADDR_W];
        r  = ref_alu(alu_op_e'(w[FUNCT_ALU_LSB +: 3]), a, b);
        if (fmt_e'(w[31:30]) == FMT_LI && w[28]) begin
            regs[0] = {{(XLEN - IMM_W){w[IMM_W-1]}}, w[IMM_W-1:0]};
        end else if (fmt_e'(w[31:30]) == FMT_R) begin
            case (w[29:28])
                K_ALU:   regs[rd] = r;
                K_LOAD:  regs[rd] = exp_mem[mem_index(r)];
                K_STORE: begin
                    exp_addr.push_back(r);
                    exp_data.push_back(b);       // Store data is rt
                    exp_mem[mem_index(r)] = b;
                end
                default: ;                       // ALU op without write-back
            endcase
        end
        // Branch and jump formats do nothing here
    end
endfunction

`endif

// ==== tests/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ();

    localparam int    CLK_PERIOD = 20;
    localparam int    RST_CYCLES = 10;
    localparam int    PROG_AW    = 7;
    localparam int    PROG_MAX   = 1 << PROG_AW;   // Program words, NOP beyond
    localparam int    DMEM_AW    = 8;
    localparam int    DMEM_DEPTH = 1 << DMEM_AW;
    localparam word_t SEED       = 32'hefd5;

    // R-format kinds in op bits 29:28
    localparam logic [1:0] K_ALU   = 2'b01;
    localparam logic [1:0] K_STORE = 2'b10;
    localparam logic [1:0] K_LOAD  = 2'b11;

    logic  clk;
    logic  rst;
    word_t i_data;
    word_t d_data_i;
    word_t i_addr;
    word_t d_addr;
    word_t d_data_o;
    logic  d_wr;
    logic  d_rd;

    word_t prog [PROG_MAX];           // Doubles as instruction memory
    int    prog_len;
    word_t dmem [DMEM_DEPTH];
    word_t exp_mem [DMEM_DEPTH];      // Model memory image
    word_t exp_addr [$];              // Model stores in order
    word_t exp_data [$];
    word_t lfsr;
    string test_name;
    int    test_errors;
    int    store_count;
    int    tests_run;
    int    tests_failed;
    int    total_errors;

    `include "cpu_tb_model.svh"

    cpu_top UUT (
        .clk      (clk),
        .rst      (rst),
        .i_data   (i_data),
        .d_data_i (d_data_i),
        .i_addr   (i_addr),
        .d_addr   (d_addr),
        .d_data_o (d_data_o),
        .d_wr     (d_wr),
        .d_rd     (d_rd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign i_data   = (i_addr < PROG_MAX * PC_STEP) ? prog[i_addr[2 +: PROG_AW]] : NOP_INSN;
    assign d_data_i = (d_rd === 1'b1) ? dmem[d_addr[2 +: DMEM_AW]] : '0;

    always @(posedge clk) begin
        if (d_wr === 1'b1) begin
            dmem[d_addr[2 +: DMEM_AW]] = d_data_o;
        end
    end

    task automatic check_word(string what, word_t exp, word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (act != exp) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    // Store monitor, in-order against the model list
    always @(negedge clk) begin
        if (d_wr === 1'b1) begin
            if (store_count < exp_addr.size()) begin
                check_word("store address", exp_addr[store_count], d_addr);
                check_word("store data", exp_data[store_count], d_data_o);
            end else begin
                $display("ERROR %s: store to %h comes after all expected stores",
                         test_name, d_addr);
                test_errors++;
            end
            store_count++;
        end
    end

    function automatic void clear_program();
        for (int i = 0; i < PROG_MAX; i++) begin
            prog[i] = NOP_INSN;
        end
        prog_len = 0;
    endfunction

    function automatic void emit(word_t w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    // r1..r7 via r0, then a fresh r0
    function automatic void load_regs();
        for (int k = 1; k < 8; k++) begin
            emit(enc_li(rand_bits(IMM_W)));
            emit(enc_r(K_ALU, ALU_PASS_A, '0, '0, reg_addr_t'(k)));
        end
        emit(enc_li(rand_bits(IMM_W)));
    endfunction

    function automatic void dump_regs();
        for (int k = 0; k < 8; k++) begin
            emit(enc_r(K_STORE, ALU_ADD, reg_addr_t'(k), reg_addr_t'(k), '0));
        end
    endfunction

    // Sources taken from the last two destinations, so both forward paths see use
    function automatic void gen_random(int n, logic with_loads, logic with_dropped);
        reg_addr_t  d1;
        reg_addr_t  d2;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [1:0] pick;
        d1 = 5'd1;
        d2 = 5'd2;
        for (int i = 0; i < n; i++) begin
            pick = rand_bits(2);
            rs   = pick[0] ? d1 : d2;
            rt   = pick[1] ? d2 : reg_addr_t'(rand_bits(3));
            rd   = reg_addr_t'(rand_bits(3));
            if (with_loads && rand_bits(2) == 0) begin
                emit(enc_r(K_LOAD, alu_op_e'(i % 8), rs, rt, rd));
            end else begin
                emit(enc_r(K_ALU, alu_op_e'(i % 8), rs, rt, rd));   // Every op in turn
            end
            if (with_dropped && rand_bits(1)) begin
                emit(32'h8000_0000 | rand_bits(31));   // Branch or jump word
            end
            if (rand_bits(1)) begin
                emit(enc_r(K_STORE, ALU_PASS_A, reg_addr_t'(rand_bits(3)), rd, '0));
            end
            d2 = d1;
            d1 = rd;
        end
    endfunction

    // Load, then its rd consumed right away as rs or rt
    function automatic void gen_load_use(int n);
        reg_addr_t  ra;
        reg_addr_t  rd;
        reg_addr_t  other;
        logic [1:0] use_kind;
        for (int i = 0; i < n; i++) begin
            ra       = reg_addr_t'(rand_bits(3));
            rd       = reg_addr_t'(rand_bits(3));
            other    = reg_addr_t'(rand_bits(3));
            use_kind = rand_bits(2);
            emit(enc_r(K_LOAD, ALU_PASS_A, ra, other, rd));
            if (use_kind[1]) begin
                emit(enc_r(K_STORE, ALU_PASS_A, use_kind[0] ? rd : other,
                           use_kind[0] ? other : rd, '0));        // Address or data
            end else begin
                emit(enc_r(K_ALU, ALU_XOR, use_kind[0] ? rd : other,
                           use_kind[0] ? other : rd, other));
                emit(enc_r(K_STORE, ALU_PASS_A, ra, other, '0));
            end
        end
    endfunction

    // Called on a falling edge with rst high
    task automatic begin_test(string name);
        test_name   = name;
        test_errors = 0;
        store_count = 0;
        run_model(prog_len);
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = fill_word(i);
        end
        rst = 1'b1;
        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_bit("write strobe in reset", 1'b0, d_wr);
            check_bit("read strobe in reset", 1'b0, d_rd);
            check_word("fetch address in reset", '0, i_addr);
        end
        rst = 1'b0;
    endtask

    // Sequential fetch and quiet strobes until the first store reaches MEM
    task automatic check_fetch_ramp(int store_index);
        for (int k = 1; k < store_index + 3; k++) begin
            @(negedge clk);
            check_word("fetch address", word_t'(k) * PC_STEP, i_addr);
            check_bit("write strobe", 1'b0, d_wr);
            check_bit("read strobe", 1'b0, d_rd);
        end
        @(negedge clk);
        check_bit("first store strobe", 1'b1, d_wr);
    endtask

    task automatic finish_test();
        int    cycles;
        logic  done;
        word_t drain_addr;
        cycles     = 0;
        drain_addr = word_t'(prog_len + 4) * PC_STEP;   // Last word past WB
        done       = (i_addr >= drain_addr);
        while (done !== 1'b1 && cycles < prog_len * 3) begin
            @(negedge clk);
            cycles++;
            done = (i_addr >= drain_addr);
        end
        if (done !== 1'b1) begin
            $display("ERROR %s: timeout, program did not drain in %0d cycles", test_name, cycles);
            test_errors++;
        end
        check_count("store count", exp_addr.size(), store_count);
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            check_word($sformatf("memory word %0d", i), exp_mem[i], dmem[i]);
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
        rst = 1'b1;             // Park the core before the next program is written
    endtask

    initial begin
        rst          = 1'b1;
        lfsr         = SEED;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;

        clear_program();
        emit(enc_li(rand_bits(IMM_W)));
        emit(enc_r(K_ALU, ALU_ADD, '0, '0, 5'd1));
        emit(NOP_INSN);
        emit(enc_r(K_STORE, ALU_ADD, 5'd1, '0, '0));
        begin_test("reset");
        check_fetch_ramp(3);
        finish_test();

        // Immediate then store of r0, gap of 0 to 3 NOPs
        clear_program();
        for (int i = 0; i < 10; i++) begin
            emit(enc_li(rand_bits(IMM_W)));
            repeat (rand_bits(2)) emit(NOP_INSN);
            emit(enc_r(K_STORE, alu_op_e'(rand_bits(3)), '0, '0, '0));
        end
        begin_test("load_imm");
        finish_test();

        clear_program();
        load_regs();
        gen_random(32, 1'b0, 1'b0);
        dump_regs();
        begin_test("alu_chain");
        finish_test();

        clear_program();
        load_regs();
        gen_load_use(12);
        dump_regs();
        begin_test("load_use");
        finish_test();

        clear_program();
        load_regs();
        gen_random(30, 1'b1, 1'b1);
        dump_regs();
        begin_test("dropped_fmt");
        finish_test();

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== rtl/cpu_top.sv ====
module cpu_top import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t i_data,
    input  word_t d_data_i,
    output word_t i_addr,
    output word_t d_addr,
    output word_t d_data_o,
    output logic  d_wr,
    output logic  d_rd
);

    word_t     if_ir;
    logic      stall;

    // ID and register file
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    // ID/EX
    reg_addr_t ex_rs;
    reg_addr_t ex_rt;
    reg_addr_t ex_rd;
    word_t     ex_a;
    word_t     ex_b;
    word_t     ex_imm;
    alu_op_e   ex_alu_op;
    logic      ex_alu_src;
    logic      ex_mem_rd;
    logic      ex_mem_wr;
    logic      ex_wr_reg;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    // EX/MEM
    word_t     mem_addr;
    word_t     mem_wdata;
    reg_addr_t mem_wb_reg;
    logic      mem_rd;
    logic      mem_wr;
    logic      mem_wr_reg;

    // MEM/WB
    word_t     wb_data;
    reg_addr_t wb_reg;
    logic      wb_wr;

    fetch_stage u_fetch (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .i_data (i_data),
        .i_addr (i_addr),
        .if_ir  (if_ir)
    );

    reg_file u_regs (
        .clk     (clk),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_addr (wb_reg),
        .wr_data (wb_data),
        .wr      (wb_wr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_ir      (if_ir),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .ex_rs      (ex_rs),
        .ex_rt      (ex_rt),
        .ex_rd      (ex_rd),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .ex_imm     (ex_imm),
        .ex_alu_op  (ex_alu_op),
        .ex_alu_src (ex_alu_src),
        .ex_mem_rd  (ex_mem_rd),
        .ex_mem_wr  (ex_mem_wr),
        .ex_wr_reg  (ex_wr_reg)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst        (rst),
        .ex_rd      (ex_rd),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .ex_imm     (ex_imm),
        .ex_alu_op  (ex_alu_op),
        .ex_alu_src (ex_alu_src),
        .ex_mem_rd  (ex_mem_rd),
        .ex_mem_wr  (ex_mem_wr),
        .ex_wr_reg  (ex_wr_reg),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .wb_data    (wb_data),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wb_reg (mem_wb_reg),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_wr_reg (mem_wr_reg)
    );

    memory_stage u_memory (
        .clk        (clk),
        .rst        (rst),
        .mem_addr   (mem_addr),
        .mem_wb_reg (mem_wb_reg),
        .mem_rd     (mem_rd),
        .mem_wr_reg (mem_wr_reg),
        .d_data_i   (d_data_i),
        .wb_data    (wb_data),
        .wb_reg     (wb_reg),
        .wb_wr      (wb_wr)
    );

    hazard_unit u_hazard (
        .id_rs      (rs_addr),
        .id_rt      (rt_addr),
        .ex_rs      (ex_rs),
        .ex_rt      (ex_rt),
        .ex_rd      (ex_rd),
        .mem_wb_reg (mem_wb_reg),
        .wb_reg     (wb_reg),
        .ex_mem_rd  (ex_mem_rd),
        .mem_wr_reg (mem_wr_reg),
        .wb_wr      (wb_wr),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .stall      (stall)
    );

    // Data memory port is the EX/MEM register
    assign d_addr   = mem_addr;
    assign d_data_o = mem_wdata;
    assign d_wr     = mem_wr;
    assign d_rd     = mem_rd;

endmodule

// ==== rtl/hazard_unit.sv ====
module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t id_rs,       // Sources of the instruction in ID
    input  reg_addr_t id_rt,
    input  reg_addr_t ex_rs,       // Sources of the instruction in EX
    input  reg_addr_t ex_rt,
    input  reg_addr_t ex_rd,
    input  reg_addr_t mem_wb_reg,  // Destination in EX/MEM
    input  reg_addr_t wb_reg,      // Destination in MEM/WB
    input  logic      ex_mem_rd,   // Instruction in EX is a load
    input  logic      mem_wr_reg,
    input  logic      wb_wr,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output logic      stall
);

    // Newest producer wins
    function automatic fwd_sel_e fwd_pick(reg_addr_t src, logic mem_hit_en,
                                          reg_addr_t mem_dst, logic wb_hit_en,
                                          reg_addr_t wb_dst);
        if (mem_hit_en && (mem_dst == src)) begin
            return FWD_MEM;
        end
        if (wb_hit_en && (wb_dst == src)) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a = fwd_pick(ex_rs, mem_wr_reg, mem_wb_reg, wb_wr, wb_reg);
    assign fwd_b = fwd_pick(ex_rt, mem_wr_reg, mem_wb_reg, wb_wr, wb_reg);

    // Load result is not ready until MEM/WB, so the consumer waits one cycle.
    // The bubble that follows has no load strobe, which ends the stall by itself.
    // Store data on rt is covered here as well
    assign stall = ex_mem_rd && ((ex_rd == id_rs) || (ex_rd == id_rt));

endmodule

// ==== rtl/memory_stage.sv ====
module memory_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     mem_addr,    // ALU result of the instruction in MEM
    input  reg_addr_t mem_wb_reg,
    input  logic      mem_rd,
    input  logic      mem_wr_reg,
    input  word_t     d_data_i,    // Valid while d_rd is high
    output word_t     wb_data,
    output reg_addr_t wb_reg,
    output logic      wb_wr
);

    word_t load_data;
    word_t alu_data;
    logic  wb_is_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_is_load <= 1'b0;
            wb_wr      <= 1'b0;
        end else begin
            wb_is_load <= mem_rd;
            wb_wr      <= mem_wr_reg;
        end
    end

    always_ff @(posedge clk) begin
        load_data <= d_data_i;
        alu_data  <= mem_addr;
        wb_reg    <= mem_wb_reg;
    end

    assign wb_data = wb_is_load ? load_data : alu_data;  // Write-back source

endmodule

// ==== rtl/execute_stage.sv ====
module execute_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t ex_rd,
    input  word_t     ex_a,
    input  word_t     ex_b,
    input  word_t     ex_imm,
    input  alu_op_e   ex_alu_op,
    input  logic      ex_alu_src,
    input  logic      ex_mem_rd,
    input  logic      ex_mem_wr,
    input  logic      ex_wr_reg,
    input  fwd_sel_e  fwd_a,
    input  fwd_sel_e  fwd_b,
    input  word_t     wb_data,     // MEM/WB result for the older producer
    output word_t     mem_addr,    // EX/MEM ALU result, also the data address
    output word_t     mem_wdata,   // Store data
    output reg_addr_t mem_wb_reg,
    output logic      mem_rd,
    output logic      mem_wr,
    output logic      mem_wr_reg
);

    word_t opnd_a;       // Forwarded rs value
    word_t opnd_b;       // Forwarded rt value, also store data
    word_t alu_a;
    word_t alu_result;

    // Shared operand mux for both ALU inputs
    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t wb_val,
                                      word_t mem_val);
        case (sel)
            FWD_WB:  return wb_val;
            FWD_MEM: return mem_val;
            default: return reg_val;
        endcase
    endfunction

    assign opnd_a = fwd_mux(fwd_a, ex_a, wb_data, mem_addr);
    assign opnd_b = fwd_mux(fwd_b, ex_b, wb_data, mem_addr);
    assign alu_a  = ex_alu_src ? ex_imm : opnd_a;  // Load immediate

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:    alu_result = alu_a + opnd_b;
            ALU_SUB:    alu_result = alu_a - opnd_b;
            ALU_AND:    alu_result = alu_a & opnd_b;
            ALU_OR:     alu_result = alu_a | opnd_b;
            ALU_XOR:    alu_result = alu_a ^ opnd_b;
            ALU_NOR:    alu_result = ~(alu_a | opnd_b);
            ALU_PASS_A: alu_result = alu_a;
            default:    alu_result = opnd_b;   // ALU_PASS_B
        endcase
    end

    // EX/MEM strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rd     <= 1'b0;
            mem_wr     <= 1'b0;
            mem_wr_reg <= 1'b0;
        end else begin
            mem_rd     <= ex_mem_rd;
            mem_wr     <= ex_mem_wr;
            mem_wr_reg <= ex_wr_reg;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        mem_addr   <= alu_result;
        mem_wdata  <= opnd_b;
        mem_wb_reg <= ex_rd;
    end

endmodule

// ==== rtl/decode_stage.sv ====
module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  word_t     if_ir,
    input  word_t     rs_data,
    input  word_t     rt_data,
    output reg_addr_t rs_addr,     // Register file read ports, also seen by hazard unit
    output reg_addr_t rt_addr,
    output reg_addr_t ex_rs,       // ID/EX register follows
    output reg_addr_t ex_rt,
    output reg_addr_t ex_rd,
    output word_t     ex_a,
    output word_t     ex_b,
    output word_t     ex_imm,
    output alu_op_e   ex_alu_op,
    output logic      ex_alu_src,  // Immediate replaces operand A
    output logic      ex_mem_rd,
    output logic      ex_mem_wr,
    output logic      ex_wr_reg
);

    logic [OP_W-1:0] op;
    fmt_e            fmt;
    reg_addr_t       rd;
    word_t           imm_se;
    alu_op_e         alu_op;
    logic            is_r;
    logic            is_li;
    logic            issue;
    logic            id_mem_rd;
    logic            id_mem_wr;
    logic            id_wr_reg;

    // Field split
    assign op      = if_ir[OP_MSB -: OP_W];
    assign fmt     = fmt_e'(if_ir[OP_MSB -: $bits(fmt_e)]);
    assign rs_addr = if_ir[RS_LSB +: REG_ADDR_W];
    assign rt_addr = if_ir[RT_LSB +: REG_ADDR_W];
    assign rd      = if_ir[RD_LSB +: REG_ADDR_W];
    assign alu_op  = alu_op_e'(if_ir[FUNCT_ALU_LSB +: $bits(alu_op_e)]);
    assign imm_se  = {{(XLEN - IMM_W){if_ir[IMM_W-1]}}, if_ir[IMM_W-1:0]};  // Sign extend

    assign is_r  = (fmt == FMT_R);
    assign is_li = (fmt == FMT_LI);
    // Branch and jump words fall out here and travel as bubbles
    assign issue = (is_r || is_li) && !stall;

    assign id_mem_rd = is_r & op[3] & op[2];      // Load
    assign id_mem_wr = is_r & op[3] & ~op[2];     // Store, never writes back
    assign id_wr_reg = (is_r | is_li) & op[2];    // Write-back enable bit

    // ID/EX strobes, cleared for a bubble
    always_ff @(posedge clk) begin
        if (rst || !issue) begin
            ex_alu_src <= 1'b0;
            ex_mem_rd  <= 1'b0;
            ex_mem_wr  <= 1'b0;
            ex_wr_reg  <= 1'b0;
        end else begin
            ex_alu_src <= is_li;
            ex_mem_rd  <= id_mem_rd;
            ex_mem_wr  <= id_mem_wr;
            ex_wr_reg  <= id_wr_reg;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        ex_a      <= rs_data;
        ex_b      <= rt_data;
        ex_rs     <= rs_addr;
        ex_rt     <= rt_addr;
        ex_rd     <= is_li ? reg_addr_t'(0) : rd;   // Load immediate lands in r0
        ex_imm    <= imm_se;
        ex_alu_op <= is_li ? ALU_PASS_A : alu_op;   // Immediate passes through A
    end

endmodule

// ==== rtl/reg_file.sv ====
module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  logic      wr,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [NUM_REGS];  // r0 is an ordinary register, target of load immediate

    always_ff @(posedge clk) begin
        if (wr) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write shows through to the reader in ID
    assign rs_data = (wr && (wr_addr == rs_addr)) ? wr_data : regs[rs_addr];
    assign rt_data = (wr && (wr_addr == rt_addr)) ? wr_data : regs[rt_addr];

endmodule

// ==== rtl/fetch_stage.sv ====
module fetch_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,      // Load-use hold, one cycle at a time
    input  word_t i_data,     // Instruction memory answers in the same cycle
    output word_t i_addr,
    output word_t if_ir       // IF/ID instruction register
);

    word_t pc;
    word_t pc_inc;

    assign pc_inc = pc + PC_STEP;  // No branch targets, so always sequential
    assign i_addr = pc;

    // PC and IF/ID advance together, both frozen during a stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= '0;
            if_ir <= NOP_INSN;     // Empty IF/ID after reset
        end else if (!stall) begin
            pc    <= pc_inc;
            if_ir <= i_data;
        end
    end

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    // Datapath geometry
    localparam int XLEN       = 32;       // Data and address width
    localparam int REG_ADDR_W = 5;        // Register number width
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t PC_STEP  = 4;      // Byte step between instruction words
    localparam word_t NOP_INSN = '0;     // All-zero word decodes as R-format with no strobes

    // Instruction field positions
    localparam int OP_MSB        = 31;
    localparam int OP_W          = 6;    // R-format op field 31:26
    localparam int RS_LSB        = 21;   // rs at 25:21
    localparam int RT_LSB        = 16;   // rt at 20:16
    localparam int RD_LSB        = 11;   // rd at 15:11
    localparam int FUNCT_ALU_LSB = 3;    // ALU op sits in funct 5:3
    localparam int IMM_W         = 26;   // Load immediate field 25:0

    // Format from the two top op bits
    typedef enum logic [1:0] {
        FMT_R      = 2'b00,
        FMT_LI     = 2'b01,              // Sign-extended immediate into r0
        FMT_BRANCH = 2'b10,              // Decoded, executed as a NOP
        FMT_JUMP   = 2'b11               // Decoded, executed as a NOP
    } fmt_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_NOR    = 3'd5,
        ALU_PASS_A = 3'd6,
        ALU_PASS_B = 3'd7
    } alu_op_e;

    // ALU operand source, priority MEM over WB is resolved in the hazard unit
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,                 // Value read in ID
        FWD_WB  = 2'b01,                 // MEM/WB write-back data
        FWD_MEM = 2'b10                  // EX/MEM ALU result
    } fwd_sel_e;

endpackage
